//--- logic/ooo_pkg.sv
package ooo_pkg;

    // Physical register tag width
    localparam int TAG_BITS = 6;

    // Data path width for RV32I
    localparam int XLEN = 32;

    // Operation width, matches the enum encoding below
    localparam int OP_BITS = 3;

    // Renamed operation kinds
    // ALU kinds first, the only multiplier kind last
    typedef enum logic [OP_BITS-1:0] {
        // rd = rs1 + rs2
        ADD = 3'd0,
        // rd = rs1 - rs2
        SUB = 3'd1,
        // Bitwise and
        AND = 3'd2,
        // Bitwise or
        OR  = 3'd3,
        // Bitwise exclusive or
        XOR = 3'd4,
        // Left shift by rs2[4:0]
        SLL = 3'd5,
        // Logical right shift by rs2[4:0]
        SRL = 3'd6,
        // Low 32 bits of rs1 * rs2
        MUL = 3'd7
    } op_kind_t;

    // Unit classification
    // True only for operations that go to the multiplier,
    // everything else runs on the ALU
    function automatic logic is_mul_op(op_kind_t op);
        return op == MUL;
    endfunction

endpackage

//--- logic/issue_station.sv
module issue_station
    import ooo_pkg::*;
#(
    parameter int STATION_DEPTH = 8
) (
    input  logic                clk,
    input  logic                rst,
    // Dispatch side, one instruction per cycle under credit control
    input  logic                dispatch_valid,
    input  op_kind_t            dispatch_op,
    input  logic [TAG_BITS-1:0] dispatch_dest_tag,
    input  logic [TAG_BITS-1:0] dispatch_src1_tag,
    input  logic                dispatch_src1_ready,
    input  logic [XLEN-1:0]     dispatch_src1_value,
    input  logic [TAG_BITS-1:0] dispatch_src2_tag,
    input  logic                dispatch_src2_ready,
    input  logic [XLEN-1:0]     dispatch_src2_value,
    // Unit availability
    input  logic                alu_free,
    input  logic                mul_free,
    // Common data bus for wakeup
    input  logic                cdb_valid,
    input  logic [TAG_BITS-1:0] cdb_tag,
    input  logic [XLEN-1:0]     cdb_value,
    // Issue to the ALU
    output logic                alu_issue,
    output op_kind_t            issue_op,
    output logic [XLEN-1:0]     alu_src1,
    output logic [XLEN-1:0]     alu_src2,
    output logic [TAG_BITS-1:0] alu_dest_tag,
    // Issue to the multiplier
    output logic                mul_issue,
    output logic [XLEN-1:0]     mul_src1,
    output logic [XLEN-1:0]     mul_src2,
    output logic [TAG_BITS-1:0] mul_dest_tag,
    // Entries freed last cycle, 0 to 2
    output logic [1:0]          credit_return
);

    localparam int IDX_BITS = $clog2(STATION_DEPTH);

    // Occupancy per entry
    logic [STATION_DEPTH-1:0] ent_valid;

    // Entry payload
    op_kind_t            ent_op       [STATION_DEPTH];
    logic [TAG_BITS-1:0] ent_dest     [STATION_DEPTH];
    logic [TAG_BITS-1:0] ent_src1_tag [STATION_DEPTH];
    logic [TAG_BITS-1:0] ent_src2_tag [STATION_DEPTH];
    logic [XLEN-1:0]     ent_src1_val [STATION_DEPTH];
    logic [XLEN-1:0]     ent_src2_val [STATION_DEPTH];
    logic [STATION_DEPTH-1:0] ent_src1_rdy;
    logic [STATION_DEPTH-1:0] ent_src2_rdy;

    // Selection results
    logic [IDX_BITS-1:0] ins_idx;
    logic [IDX_BITS-1:0] alu_idx;
    logic [IDX_BITS-1:0] mul_idx;
    logic                alu_found;
    logic                mul_found;

    // Broadcast that matches a source being dispatched right now
    logic src1_hit;
    logic src2_hit;

    assign src1_hit = cdb_valid && !dispatch_src1_ready && (cdb_tag == dispatch_src1_tag);
    assign src2_hit = cdb_valid && !dispatch_src2_ready && (cdb_tag == dispatch_src2_tag);

    // Priority pick, scanning down so the lowest index wins
    always_comb begin
        ins_idx   = '0;
        alu_idx   = '0;
        mul_idx   = '0;
        alu_found = 1'b0;
        mul_found = 1'b0;
        for (int i = STATION_DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                ins_idx = IDX_BITS'(i);
            end
            if (ent_valid[i] && ent_src1_rdy[i] && ent_src2_rdy[i]) begin
                if (is_mul_op(ent_op[i])) begin
                    mul_idx   = IDX_BITS'(i);
                    mul_found = 1'b1;
                end else begin
                    alu_idx   = IDX_BITS'(i);
                    alu_found = 1'b1;
                end
            end
        end
    end

    // Issue only into a unit that can take it this cycle
    assign alu_issue = alu_found && alu_free;
    assign mul_issue = mul_found && mul_free;

    assign issue_op     = ent_op[alu_idx];
    assign alu_src1     = ent_src1_val[alu_idx];
    assign alu_src2     = ent_src2_val[alu_idx];
    assign alu_dest_tag = ent_dest[alu_idx];

    assign mul_src1     = ent_src1_val[mul_idx];
    assign mul_src2     = ent_src2_val[mul_idx];
    assign mul_dest_tag = ent_dest[mul_idx];

    // Occupancy and credit count
    always_ff @(posedge clk) begin
        if (rst) begin
            ent_valid     <= '0;
            credit_return <= '0;
        end else begin
            if (alu_issue) begin
                ent_valid[alu_idx] <= 1'b0;
            end
            if (mul_issue) begin
                ent_valid[mul_idx] <= 1'b0;
            end
            // The insert slot is free, so it never collides with an issuing entry
            if (dispatch_valid) begin
                ent_valid[ins_idx] <= 1'b1;
            end
            credit_return <= {1'b0, alu_issue} + {1'b0, mul_issue};
        end
    end

    // Wakeup and insert
    always_ff @(posedge clk) begin
        for (int i = 0; i < STATION_DEPTH; i++) begin
            if (cdb_valid && !ent_src1_rdy[i] && (ent_src1_tag[i] == cdb_tag)) begin
                ent_src1_rdy[i] <= 1'b1;
                ent_src1_val[i] <= cdb_value;
            end
            if (cdb_valid && !ent_src2_rdy[i] && (ent_src2_tag[i] == cdb_tag)) begin
                ent_src2_rdy[i] <= 1'b1;
                ent_src2_val[i] <= cdb_value;
            end
        end
        // New entry overrides any wakeup on its slot
        if (dispatch_valid) begin
            ent_op[ins_idx]       <= dispatch_op;
            ent_dest[ins_idx]     <= dispatch_dest_tag;
            ent_src1_tag[ins_idx] <= dispatch_src1_tag;
            ent_src2_tag[ins_idx] <= dispatch_src2_tag;
            ent_src1_rdy[ins_idx] <= dispatch_src1_ready || src1_hit;
            ent_src2_rdy[ins_idx] <= dispatch_src2_ready || src2_hit;
            // Take the bus value when the producer broadcasts this same cycle
            ent_src1_val[ins_idx] <= dispatch_src1_ready ? dispatch_src1_value : cdb_value;
            ent_src2_val[ins_idx] <= dispatch_src2_ready ? dispatch_src2_value : cdb_value;
        end
    end

endmodule

//--- logic/alu_unit.sv
module alu_unit
    import ooo_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    // Issue from the station
    input  logic                issue,
    input  op_kind_t            op,
    input  logic [XLEN-1:0]     src1,
    input  logic [XLEN-1:0]     src2,
    input  logic [TAG_BITS-1:0] dest_tag,
    // Bus grant for the held result
    input  logic                grant,
    output logic                free,
    output logic                req,
    output logic [TAG_BITS-1:0] result_tag,
    output logic [XLEN-1:0]     result_value
);

    logic [XLEN-1:0] alu_out;
    logic [4:0]      shamt;

    // RV32I shifts use only the low five bits
    assign shamt = src2[4:0];

    always_comb begin
        case (op)
            ADD:     alu_out = src1 + src2;
            SUB:     alu_out = src1 - src2;
            AND:     alu_out = src1 & src2;
            OR:      alu_out = src1 | src2;
            XOR:     alu_out = src1 ^ src2;
            SLL:     alu_out = src1 << shamt;
            SRL:     alu_out = src1 >> shamt;
            // MUL never reaches this unit
            default: alu_out = '0;
        endcase
    end

    // Empty register, or one that drains this cycle
    assign free = !req || grant;

    // Result valid flag
    always_ff @(posedge clk) begin
        if (rst) begin
            req <= 1'b0;
        end else if (issue) begin
            req <= 1'b1;
        end else if (grant) begin
            req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            result_tag   <= dest_tag;
            result_value <= alu_out;
        end
    end

endmodule

//--- logic/mul_unit.sv
module mul_unit
    import ooo_pkg::*;
#(
    parameter int MUL_STAGES = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                issue,
    input  logic [XLEN-1:0]     src1,
    input  logic [XLEN-1:0]     src2,
    input  logic [TAG_BITS-1:0] dest_tag,
    input  logic                grant,
    output logic                free,
    output logic                req,
    output logic [TAG_BITS-1:0] result_tag,
    output logic [XLEN-1:0]     result_value
);

    // Multiplier bits handled per stage, src2 padded to a whole number of chunks
    localparam int CHUNK    = (XLEN + MUL_STAGES - 1) / MUL_STAGES;
    localparam int PAD_BITS = CHUNK * MUL_STAGES;

    // Stage 0 holds operands, stage k holds the sum of the first k partials
    logic [MUL_STAGES:0] stage_valid;
    logic [TAG_BITS-1:0] stage_tag [MUL_STAGES+1];
    logic [XLEN-1:0]     stage_a   [MUL_STAGES];
    logic [PAD_BITS-1:0] stage_b   [MUL_STAGES];
    logic [XLEN-1:0]     stage_acc [MUL_STAGES];
    logic [XLEN-1:0]     partial   [MUL_STAGES];
    logic                advance;

    // Whole pipe freezes while the last stage waits for the bus
    assign advance = !(stage_valid[MUL_STAGES] && !grant);
    assign free    = advance;

    // Partial product of one chunk, truncated to the low word
    always_comb begin
        for (int j = 0; j < MUL_STAGES; j++) begin
            partial[j] = (stage_a[j] * XLEN'(stage_b[j][j*CHUNK +: CHUNK])) << (j * CHUNK);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= '0;
        end else if (advance) begin
            stage_valid <= {stage_valid[MUL_STAGES-1:0], issue};
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            stage_tag[0] <= dest_tag;
            stage_a[0]   <= src1;
            stage_b[0]   <= PAD_BITS'(src2);
            stage_acc[0] <= partial[0];
            for (int k = 1; k <= MUL_STAGES; k++) begin
                stage_tag[k] <= stage_tag[k-1];
            end
            for (int k = 1; k < MUL_STAGES; k++) begin
                stage_a[k]   <= stage_a[k-1];
                stage_b[k]   <= stage_b[k-1];
                stage_acc[k] <= stage_acc[k-1] + partial[k];
            end
        end
    end

    assign req          = stage_valid[MUL_STAGES];
    assign result_tag   = stage_tag[MUL_STAGES];
    assign result_value = stage_acc[MUL_STAGES-1];

endmodule

//--- logic/cdb_arbiter.sv
module cdb_arbiter
    import ooo_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    // ALU result offer
    input  logic                alu_req,
    input  logic [TAG_BITS-1:0] alu_tag,
    input  logic [XLEN-1:0]     alu_value,
    // Multiplier result offer
    input  logic                mul_req,
    input  logic [TAG_BITS-1:0] mul_tag,
    input  logic [XLEN-1:0]     mul_value,
    output logic                alu_grant,
    output logic                mul_grant,
    // Common data bus
    output logic                cdb_valid,
    output logic [TAG_BITS-1:0] cdb_tag,
    output logic [XLEN-1:0]     cdb_value
);

    // Set when the multiplier won the last grant
    logic last_mul;

    // Lone request wins at once
    // On a tie the unit that lost last time goes first
    assign alu_grant = alu_req && (!mul_req || last_mul);
    assign mul_grant = mul_req && !alu_grant;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_mul <= 1'b0;
        end else if (alu_grant) begin
            last_mul <= 1'b0;
        end else if (mul_grant) begin
            last_mul <= 1'b1;
        end
    end

    // Payload mux follows the grant in the same cycle
    assign cdb_valid = alu_req || mul_req;
    assign cdb_tag   = alu_grant ? alu_tag : mul_tag;
    assign cdb_value = alu_grant ? alu_value : mul_value;

endmodule

//--- logic/exec_cluster_top.sv
module exec_cluster_top
    import ooo_pkg::*;
#(
    parameter int STATION_DEPTH = 8,
    parameter int MUL_STAGES    = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                dispatch_valid,
    input  op_kind_t            dispatch_op,
    input  logic [TAG_BITS-1:0] dispatch_dest_tag,
    input  logic [TAG_BITS-1:0] dispatch_src1_tag,
    input  logic                dispatch_src1_ready,
    input  logic [XLEN-1:0]     dispatch_src1_value,
    input  logic [TAG_BITS-1:0] dispatch_src2_tag,
    input  logic                dispatch_src2_ready,
    input  logic [XLEN-1:0]     dispatch_src2_value,
    output logic [1:0]          credit_return,
    output logic                cdb_valid,
    output logic [TAG_BITS-1:0] cdb_tag,
    output logic [XLEN-1:0]     cdb_value
);

    // Station to ALU
    logic                alu_issue;
    op_kind_t            issue_op;
    logic [XLEN-1:0]     alu_src1;
    logic [XLEN-1:0]     alu_src2;
    logic [TAG_BITS-1:0] alu_dest_tag;
    logic                alu_free;

    // Station to multiplier
    logic                mul_issue;
    logic [XLEN-1:0]     mul_src1;
    logic [XLEN-1:0]     mul_src2;
    logic [TAG_BITS-1:0] mul_dest_tag;
    logic                mul_free;

    // Units to arbiter
    logic                alu_req;
    logic [TAG_BITS-1:0] alu_res_tag;
    logic [XLEN-1:0]     alu_res_value;
    logic                alu_grant;
    logic                mul_req;
    logic [TAG_BITS-1:0] mul_res_tag;
    logic [XLEN-1:0]     mul_res_value;
    logic                mul_grant;

    issue_station #(
        .STATION_DEPTH(STATION_DEPTH)
    ) issue_station_i (
        .clk                (clk),
        .rst                (rst),
        .dispatch_valid     (dispatch_valid),
        .dispatch_op        (dispatch_op),
        .dispatch_dest_tag  (dispatch_dest_tag),
        .dispatch_src1_tag  (dispatch_src1_tag),
        .dispatch_src1_ready(dispatch_src1_ready),
        .dispatch_src1_value(dispatch_src1_value),
        .dispatch_src2_tag  (dispatch_src2_tag),
        .dispatch_src2_ready(dispatch_src2_ready),
        .dispatch_src2_value(dispatch_src2_value),
        .alu_free           (alu_free),
        .mul_free           (mul_free),
        // Bus loops back for wakeup
        .cdb_valid          (cdb_valid),
        .cdb_tag            (cdb_tag),
        .cdb_value          (cdb_value),
        .alu_issue          (alu_issue),
        .issue_op           (issue_op),
        .alu_src1           (alu_src1),
        .alu_src2           (alu_src2),
        .alu_dest_tag       (alu_dest_tag),
        .mul_issue          (mul_issue),
        .mul_src1           (mul_src1),
        .mul_src2           (mul_src2),
        .mul_dest_tag       (mul_dest_tag),
        .credit_return      (credit_return)
    );

    alu_unit alu_unit_i (
        .clk         (clk),
        .rst         (rst),
        .issue       (alu_issue),
        .op          (issue_op),
        .src1        (alu_src1),
        .src2        (alu_src2),
        .dest_tag    (alu_dest_tag),
        .grant       (alu_grant),
        .free        (alu_free),
        .req         (alu_req),
        .result_tag  (alu_res_tag),
        .result_value(alu_res_value)
    );

    mul_unit #(
        .MUL_STAGES(MUL_STAGES)
    ) mul_unit_i (
        .clk         (clk),
        .rst         (rst),
        .issue       (mul_issue),
        .src1        (mul_src1),
        .src2        (mul_src2),
        .dest_tag    (mul_dest_tag),
        .grant       (mul_grant),
        .free        (mul_free),
        .req         (mul_req),
        .result_tag  (mul_res_tag),
        .result_value(mul_res_value)
    );

    cdb_arbiter cdb_arbiter_i (
        .clk      (clk),
        .rst      (rst),
        .alu_req  (alu_req),
        .alu_tag  (alu_res_tag),
        .alu_value(alu_res_value),
        .mul_req  (mul_req),
        .mul_tag  (mul_res_tag),
        .mul_value(mul_res_value),
        .alu_grant(alu_grant),
        .mul_grant(mul_grant),
        .cdb_valid(cdb_valid),
        .cdb_tag  (cdb_tag),
        .cdb_value(cdb_value)
    );

endmodule

//--- sim/tb_clock.sv
module tb_clock #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset held for a fixed number of rising edges, released on an edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- sim/exec_cluster_properties.sv
module exec_cluster_properties
    import ooo_pkg::*;
#(
    parameter int STATION_DEPTH = 8
) (
    input logic                clk,
    input logic                rst,
    input logic                dispatch_valid,
    input logic [1:0]          credit_return,
    input logic                cdb_valid,
    input logic [TAG_BITS-1:0] cdb_tag
);

    // Credits the dispatcher should hold, rebuilt from the port traffic
    int credits;

    // Count of failed properties, read by the testbench
    int error_count = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= STATION_DEPTH;
        end else begin
            credits <= credits + int'(credit_return) - (dispatch_valid ? 1 : 0);
        end
    end

    // No dispatch without a credit in hand
    dispatch_needs_credit: assert property (@(posedge clk) disable iff (rst)
        dispatch_valid |-> credits > 0)
    else begin
        $error("dispatch while the dispatcher holds no credit");
        error_count++;
    end

    // Two units issue at most two entries per cycle
    credit_at_most_two: assert property (@(posedge clk) disable iff (rst)
        credit_return <= 2'd2)
    else begin
        $error("credit_return above two");
        error_count++;
    end

    // Never more credits than station entries
    credit_bounded: assert property (@(posedge clk) disable iff (rst)
        credits <= STATION_DEPTH)
    else begin
        $error("credit count above station depth");
        error_count++;
    end

    // Bus and credit port quiet during reset and on the cycle after it
    quiet_in_reset: assert property (@(posedge clk)
        rst |=> (!cdb_valid && credit_return == 2'd0))
    else begin
        $error("bus or credit activity during reset");
        error_count++;
    end

    // Known control and tag once out of reset
    known_outputs: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({cdb_valid, credit_return}) && (!cdb_valid || !$isunknown(cdb_tag)))
    else begin
        $error("unknown value on bus control or credit port");
        error_count++;
    end

endmodule

bind exec_cluster_top exec_cluster_properties #(
    .STATION_DEPTH(STATION_DEPTH)
) exec_cluster_properties_i (
    .clk           (clk),
    .rst           (rst),
    .dispatch_valid(dispatch_valid),
    .credit_return (credit_return),
    .cdb_valid     (cdb_valid),
    .cdb_tag       (cdb_tag)
);

//--- sim/exec_cluster_tb.sv
module exec_cluster_tb
    import ooo_pkg::*;
#(
    parameter int STATION_DEPTH = 8,
    parameter int MUL_STAGES    = 3
);

    localparam int NUM_INSTR      = 400;
    localparam int NUM_TAGS       = 1 << TAG_BITS;
    localparam int CREDIT_TIMEOUT = 200;
    localparam int RESULT_TIMEOUT = 300;
    localparam int DRAIN_TIMEOUT  = 1000;

    logic                clk;
    logic                rst;
    logic                dispatch_valid;
    op_kind_t            dispatch_op;
    logic [TAG_BITS-1:0] dispatch_dest_tag;
    logic [TAG_BITS-1:0] dispatch_src1_tag;
    logic                dispatch_src1_ready;
    logic [XLEN-1:0]     dispatch_src1_value;
    logic [TAG_BITS-1:0] dispatch_src2_tag;
    logic                dispatch_src2_ready;
    logic [XLEN-1:0]     dispatch_src2_value;
    logic [1:0]          credit_return;
    logic                cdb_valid;
    logic [TAG_BITS-1:0] cdb_tag;
    logic [XLEN-1:0]     cdb_value;

    // Dispatcher state
    int credits;
    int cyc;
    int sent;

    // Per-tag model, one slot per physical register
    bit                  tag_busy   [NUM_TAGS];
    bit                  tag_known  [NUM_TAGS];
    logic [XLEN-1:0]     tag_value  [NUM_TAGS];
    int                  disp_cycle [NUM_TAGS];
    // Pending operands of the instruction that writes each busy tag
    op_kind_t            pend_op    [NUM_TAGS];
    bit                  pend_rdy   [NUM_TAGS][2];
    logic [TAG_BITS-1:0] pend_tag   [NUM_TAGS][2];
    logic [XLEN-1:0]     pend_val   [NUM_TAGS][2];
    bit                  exp_known  [NUM_TAGS];
    logic [XLEN-1:0]     exp_value  [NUM_TAGS];

    tb_clock #(
        .PERIOD      (40),
        .RESET_CYCLES(16)
    ) tb_clock_i (
        .clk(clk),
        .rst(rst)
    );

    exec_cluster_top #(
        .STATION_DEPTH(STATION_DEPTH),
        .MUL_STAGES   (MUL_STAGES)
    ) exec_cluster_top_i (
        .clk                (clk),
        .rst                (rst),
        .dispatch_valid     (dispatch_valid),
        .dispatch_op        (dispatch_op),
        .dispatch_dest_tag  (dispatch_dest_tag),
        .dispatch_src1_tag  (dispatch_src1_tag),
        .dispatch_src1_ready(dispatch_src1_ready),
        .dispatch_src1_value(dispatch_src1_value),
        .dispatch_src2_tag  (dispatch_src2_tag),
        .dispatch_src2_ready(dispatch_src2_ready),
        .dispatch_src2_value(dispatch_src2_value),
        .credit_return      (credit_return),
        .cdb_valid          (cdb_valid),
        .cdb_tag            (cdb_tag),
        .cdb_value          (cdb_value)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "testbench stopped at the first error");
    endtask

    // RV32I rules, multiply keeps the low word of the full product
    function automatic logic [XLEN-1:0] op_result(op_kind_t op, logic [XLEN-1:0] a,
                                                  logic [XLEN-1:0] b);
        logic [63:0] prod;
        prod = 64'(a) * 64'(b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            default: return prod[XLEN-1:0];
        endcase
    endfunction

    function automatic void resolve_if_ready(int t);
        if (pend_rdy[t][0] && pend_rdy[t][1] && !exp_known[t]) begin
            exp_value[t] = op_result(pend_op[t], pend_val[t][0], pend_val[t][1]);
            exp_known[t] = 1'b1;
        end
    endfunction

    function automatic int busy_tags();
        int n;
        n = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            n += int'(tag_busy[t]);
        end
        return n;
    endfunction

    // Immediate, completed tag, or in-flight tag; falls back to immediate
    task automatic pick_source(output logic rdy, output logic [TAG_BITS-1:0] tag,
                               output logic [XLEN-1:0] val);
        int cand[$];
        int kind;
        int pick;
        kind = $urandom_range(0, 2);
        rdy  = 1'b1;
        tag  = TAG_BITS'($urandom());
        val  = $urandom();
        for (int t = 0; t < NUM_TAGS; t++) begin
            if ((kind == 1 && tag_known[t]) || (kind == 2 && tag_busy[t])) begin
                cand.push_back(t);
            end
        end
        if (cand.size() > 0) begin
            pick = cand[$urandom_range(0, cand.size() - 1)];
            tag  = TAG_BITS'(pick);
            if (kind == 1) begin
                val = tag_value[pick];
            end else begin
                // Value left as junk, the station has to ignore it
                rdy = 1'b0;
            end
        end
    endtask

    task automatic send_instruction();
        op_kind_t            op;
        logic                rdy  [2];
        logic [TAG_BITS-1:0] stag [2];
        logic [XLEN-1:0]     sval [2];
        int                  free_tags[$];
        int                  d;
        // One in four is a multiply so both units compete for the bus
        if ($urandom_range(0, 3) == 0) begin
            op = MUL;
        end else begin
            op = op_kind_t'(OP_BITS'($urandom_range(0, 6)));
        end
        for (int s = 0; s < 2; s++) begin
            pick_source(rdy[s], stag[s], sval[s]);
        end
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (!tag_busy[t]) begin
                free_tags.push_back(t);
            end
        end
        d = free_tags[$urandom_range(0, free_tags.size() - 1)];
        tag_busy[d]   = 1'b1;
        tag_known[d]  = 1'b0;
        exp_known[d]  = 1'b0;
        pend_op[d]    = op;
        disp_cycle[d] = cyc;
        for (int s = 0; s < 2; s++) begin
            pend_rdy[d][s] = rdy[s];
            pend_tag[d][s] = stag[s];
            pend_val[d][s] = sval[s];
        end
        resolve_if_ready(d);
        dispatch_valid      <= 1'b1;
        dispatch_op         <= op;
        dispatch_dest_tag   <= TAG_BITS'(d);
        dispatch_src1_ready <= rdy[0];
        dispatch_src1_tag   <= stag[0];
        dispatch_src1_value <= sval[0];
        dispatch_src2_ready <= rdy[1];
        dispatch_src2_tag   <= stag[1];
        dispatch_src2_value <= sval[1];
        credits--;
        sent++;
    endtask

    task automatic take_broadcast(input logic [TAG_BITS-1:0] t, input logic [XLEN-1:0] v);
        int min_lat;
        assert (tag_busy[t])
        else stop_on_error($sformatf("broadcast of tag %0d, which is not in flight", t));
        assert (exp_known[t])
        else stop_on_error($sformatf("tag %0d broadcast before its operands existed", t));
        assert (v === exp_value[t])
        else stop_on_error($sformatf("mismatch at time %0t: tag %0d value %h, expected %h",
                                     $time, t, v, exp_value[t]));
        min_lat = (pend_op[t] == MUL) ? 2 + MUL_STAGES : 2;
        assert (cyc - disp_cycle[t] >= min_lat)
        else stop_on_error($sformatf("tag %0d broadcast %0d cycles after dispatch, too early",
                                     t, cyc - disp_cycle[t]));
        tag_busy[t]  = 1'b0;
        tag_known[t] = 1'b1;
        tag_value[t] = v;
        // Wake every waiting source, the same-cycle dispatch included
        for (int u = 0; u < NUM_TAGS; u++) begin
            for (int s = 0; s < 2; s++) begin
                if (tag_busy[u] && !pend_rdy[u][s] && pend_tag[u][s] == t) begin
                    pend_rdy[u][s] = 1'b1;
                    pend_val[u][s] = v;
                end
            end
            resolve_if_ready(u);
        end
    endtask

    // Sampled mid-cycle where the bus and credit port are settled
    task automatic check_outputs();
        if (cdb_valid) begin
            take_broadcast(cdb_tag, cdb_value);
        end
        credits = credits + int'(credit_return);
        assert (credits <= STATION_DEPTH)
        else stop_on_error("more credits came back than the station has entries");
        assert (exec_cluster_top_i.exec_cluster_properties_i.error_count == 0)
        else stop_on_error("a bound property failed");
        for (int t = 0; t < NUM_TAGS; t++) begin
            assert (!tag_busy[t] || cyc - disp_cycle[t] <= RESULT_TIMEOUT)
            else stop_on_error($sformatf("timeout: tag %0d was never broadcast", t));
        end
    endtask

    task automatic run_cycle(input bit want);
        @(posedge clk);
        cyc++;
        if (want && credits > 0) begin
            send_instruction();
        end else begin
            dispatch_valid <= 1'b0;
        end
        @(negedge clk);
        check_outputs();
    endtask

    initial begin
        int stall;
        int drain;
        bit want;
        void'($urandom(32'h81f9f4b3));
        dispatch_valid      = 1'b0;
        dispatch_op         = ADD;
        dispatch_dest_tag   = '0;
        dispatch_src1_tag   = '0;
        dispatch_src1_ready = 1'b1;
        dispatch_src1_value = '0;
        dispatch_src2_tag   = '0;
        dispatch_src2_ready = 1'b1;
        dispatch_src2_value = '0;
        credits = STATION_DEPTH;
        cyc     = 0;
        sent    = 0;
        stall   = 0;
        @(negedge clk);
        while (rst) begin
            assert (stall < 100) else stop_on_error("reset was never released");
            @(negedge clk);
            stall++;
        end
        stall = 0;
        while (sent < NUM_INSTR) begin
            // Roughly one idle cycle in eight
            want = ($urandom_range(0, 7) != 0);
            // Cycles spent with no credit in hand
            if (credits == 0) begin
                stall++;
            end else begin
                stall = 0;
            end
            assert (stall < CREDIT_TIMEOUT) else stop_on_error("timeout: no credit came back");
            run_cycle(want);
        end
        drain = 0;
        while ((credits != STATION_DEPTH || busy_tags() != 0) && drain < DRAIN_TIMEOUT) begin
            run_cycle(1'b0);
            drain++;
        end
        if (credits == STATION_DEPTH && busy_tags() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            stop_on_error("timeout: station never drained");
        end
    end

endmodule

//--- verilog.f
logic/ooo_pkg.sv
logic/issue_station.sv
logic/alu_unit.sv
logic/mul_unit.sv
logic/cdb_arbiter.sv
logic/exec_cluster_top.sv
sim/tb_clock.sv
sim/exec_cluster_properties.sv
sim/exec_cluster_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
    --top-module exec_cluster_tb \
    -f verilog.f \
    -o exec_cluster_sim
./obj_dir/exec_cluster_sim
